/* Makefile */
# Verilator build and run for the P-A unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pa_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/pa_tb.sv */
// Testbench for the P-A unit running directed tests against a reference model of ac, ar and ic

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_tb;

	localparam int W = `PA_WORD_WIDTH;
	// well above the hundred or so cycles the tests take
	localparam int max_cycles = 2000;

	logic         clk;
	logic         reset;
	logic         cmd_valid;
	logic         cmd_ready;
	pa_pkg::pa_op cmd_op;
	logic [0:W-1] cmd_data;
	logic         rsp_valid;
	logic         rsp_ready;
	logic [0:W-1] rsp_data;
	logic         rsp_zero;
	logic         rsp_carry;
	logic         rsp_sign;
	logic [0:W-1] rsp_addr;
	logic         rsp_match;
	logic [0:W-1] key;

	// reference model state
	logic [0:W-1] ac_m;
	logic [0:W-1] ar_m;
	logic [0:W-1] ic_m;

	// expected response of the last accepted command
	logic [0:W-1] exp_data;
	logic         exp_zero;
	logic         exp_carry;
	logic         exp_sign;
	logic [0:W-1] exp_addr;
	logic         exp_match;

	int     errors;
	int     cycles = 0;
	integer seed;
	string  test_name;

	pa_top dut_i (
		.__clk     (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data),
		.rsp_zero  (rsp_zero),
		.rsp_carry (rsp_carry),
		.rsp_sign  (rsp_sign),
		.rsp_addr  (rsp_addr),
		.rsp_match (rsp_match),
		.key       (key)
	);

	always #50 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run stopped after %0d cycles in test %s", cycles, test_name);
			$display("errors: %0d", errors);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_word(input string field, input logic [0:W-1] expected,
		input logic [0:W-1] actual);
		assert (actual === expected) else begin
			errors++;
			$display("error: %s %s expected %h got %h", test_name, field, expected, actual);
		end
	endtask

	task automatic check_bit(input string field, input logic expected, input logic actual);
		assert (actual === expected) else begin
			errors++;
			$display("error: %s %s expected %b got %b", test_name, field, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("%s: %s", test_name, what);
		end
	endtask

	// model step that sets the expected response and updates ac, ar and ic
	task automatic predict(input pa_pkg::pa_op op, input logic [0:W-1] data);
		logic [16:0] sum;
		exp_carry = 1'b0;
		exp_addr = (op == pa_pkg::op_fetch) ? ic_m : ar_m;
		exp_match = (exp_addr == key);
		case (op)
			pa_pkg::op_load: exp_data = data;
			pa_pkg::op_add: begin
				sum = {1'b0, ac_m} + {1'b0, data};
				exp_data = sum[15:0];
				exp_carry = sum[16];
			end
			pa_pkg::op_sub: begin
				sum = {1'b0, ac_m} + {1'b0, ~data} + 17'd1;
				exp_data = sum[15:0];
				exp_carry = sum[16];
			end
			pa_pkg::op_and: exp_data = ac_m & data;
			pa_pkg::op_or:  exp_data = ac_m | data;
			pa_pkg::op_xor: exp_data = ac_m ^ data;
			pa_pkg::op_load_ar: begin
				exp_data = data;
				ar_m = data;
			end
			pa_pkg::op_load_ic: begin
				exp_data = data;
				ic_m = data;
			end
			default: begin
				exp_data = ic_m;
				ic_m = ic_m + 16'd1;
			end
		endcase
		exp_zero = (exp_data == '0);
		exp_sign = exp_data[0];
		if (op inside {pa_pkg::op_load, pa_pkg::op_add, pa_pkg::op_sub,
			pa_pkg::op_and, pa_pkg::op_or, pa_pkg::op_xor}) begin
			ac_m = exp_data;
		end
	endtask

	task automatic check_rsp();
		check_true(rsp_valid, "no valid response one cycle after the command");
		check_word("data", exp_data, rsp_data);
		check_bit("zero", exp_zero, rsp_zero);
		check_bit("carry", exp_carry, rsp_carry);
		check_bit("sign", exp_sign, rsp_sign);
		check_word("addr", exp_addr, rsp_addr);
		check_bit("match", exp_match, rsp_match);
	endtask

	// starts and ends on a falling edge and takes one cycle when the channel is free
	task automatic exec(input pa_pkg::pa_op op, input logic [0:W-1] data);
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_data = data;
		#1;
		while (!cmd_ready) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		predict(op, data);
		@(negedge clk);
		cmd_valid = 1'b0;
		check_rsp();
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_true(!rsp_valid, "rsp_valid is high after reset");
		check_true(cmd_ready, "cmd_ready is low after reset");
		exec(pa_pkg::op_fetch, '0);
		check_word("fetch address", 16'h0000, rsp_addr);
	endtask

	task automatic test_arith();
		logic [31:0] a;
		logic [31:0] b;
		test_name = "arithmetic";
		for (int i = 0; i < 6; i++) begin
			a = $random(seed);
			b = $random(seed);
			// add, sub, and, or, xor after a fresh load
			for (int k = 1; k <= 5; k++) begin
				exec(pa_pkg::op_load, a[15:0]);
				exec(pa_pkg::pa_op'(k[3:0]), b[15:0]);
			end
		end
		// overflow past bit 0
		exec(pa_pkg::op_load, 16'hffff);
		exec(pa_pkg::op_add, 16'h0001);
		check_bit("overflow carry", 1'b1, rsp_carry);
		exec(pa_pkg::op_load, 16'h8000);
		exec(pa_pkg::op_add, 16'h8000);
		// equal values
		exec(pa_pkg::op_load, 16'h3c5a);
		exec(pa_pkg::op_sub, 16'h3c5a);
		check_bit("equal sub zero", 1'b1, rsp_zero);
		check_bit("equal sub carry", 1'b1, rsp_carry);
		// borrow
		exec(pa_pkg::op_load, 16'h0001);
		exec(pa_pkg::op_sub, 16'h0002);
	endtask

	task automatic test_addr();
		logic [0:W-1] start;
		test_name = "address";
		start = 16'hfffd;
		exec(pa_pkg::op_load_ar, 16'h1234);
		exec(pa_pkg::op_load_ic, start);
		// runs through the wrap from ffff to 0000
		for (int i = 0; i < 5; i++) begin
			exec(pa_pkg::op_fetch, '0);
			check_word("fetch address", start + i[15:0], rsp_addr);
		end
		exec(pa_pkg::op_or, 16'h0000);
	endtask

	task automatic test_key();
		test_name = "key match";
		key = 16'h0a5f;
		exec(pa_pkg::op_load_ar, 16'h0a5f);
		exec(pa_pkg::op_add, 16'h0001);
		check_bit("match on ar", 1'b1, rsp_match);
		exec(pa_pkg::op_load_ar, 16'h0a5e);
		exec(pa_pkg::op_xor, 16'h00ff);
		check_bit("match on ar", 1'b0, rsp_match);
		exec(pa_pkg::op_load_ic, 16'h0a5d);
		exec(pa_pkg::op_fetch, '0);
		exec(pa_pkg::op_fetch, '0);
		exec(pa_pkg::op_fetch, '0);
		check_bit("match on fetch", 1'b1, rsp_match);
	endtask

	task automatic test_backpressure();
		test_name = "back-pressure";
		// let the last response drain first
		@(negedge clk);
		rsp_ready = 1'b0;
		exec(pa_pkg::op_load, 16'h1111);
		cmd_valid = 1'b1;
		cmd_op = pa_pkg::op_add;
		cmd_data = 16'h2222;
		repeat (4) begin
			#1;
			check_true(!cmd_ready, "cmd_ready is high while the response is stalled");
			@(negedge clk);
			check_rsp();
		end
		rsp_ready = 1'b1;
		// ac must still hold the load value
		exec(pa_pkg::op_add, 16'h2222);
		check_word("ac after stall", 16'h3333, rsp_data);
	endtask

	task automatic test_throughput();
		logic [31:0] r;
		logic [31:0] d;
		int          start_cycle;
		test_name = "throughput";
		start_cycle = cycles;
		for (int i = 0; i < 8; i++) begin
			r = {$random(seed)} % 9;
			d = $random(seed);
			exec(pa_pkg::pa_op'(r[3:0]), d[15:0]);
		end
		check_true(cycles - start_cycle == 8, "commands did not transfer on every cycle");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = pa_pkg::op_load;
		cmd_data = '0;
		rsp_ready = 1'b1;
		key = '0;
		ac_m = '0;
		ar_m = '0;
		ic_m = '0;
		errors = 0;
		seed = 58744;
		test_name = "startup";
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_arith();
		test_addr();
		test_key();
		test_backpressure();
		test_throughput();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* design/pa_addr.sv */
// P-A address block with the argument register, instruction counter and key compare

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_addr (
	input  logic                      __clk,
	input  logic                      reset,
	input  logic                      fire,
	input  pa_pkg::pa_op              cmd_op,
	input  logic [0:`PA_WORD_WIDTH-1] cmd_data,
	input  logic [0:`PA_WORD_WIDTH-1] key,
	output logic [0:`PA_WORD_WIDTH-1] addr,
	output logic                      match
);

	logic [0:`PA_WORD_WIDTH-1] ar;
	logic [0:`PA_WORD_WIDTH-1] ic;
	logic [0:`PA_WORD_WIDTH-1] ic_next;

	// counter wraps from all ones to zero
	assign ic_next = ic + {{(`PA_WORD_WIDTH-1){1'b0}}, 1'b1};

	// ic goes on the bus only for fetch
	// value seen here is the one before this edge's update
	assign addr = (cmd_op == pa_pkg::op_fetch) ? ic : ar;

	// key word compare on the bus address
	assign match = (addr == key);

	always_ff @(posedge __clk) begin
		if (reset) begin
			ar <= '0;
			ic <= '0;
		end else if (fire) begin
			case (cmd_op)
				pa_pkg::op_load_ar: ar <= cmd_data;
				pa_pkg::op_load_ic: ic <= cmd_data;
				pa_pkg::op_fetch:   ic <= ic_next;
				// arithmetic ops leave both registers alone
				default: begin
					ar <= ar;
					ic <= ic;
				end
			endcase
		end
	end

	// a taken fetch moves ic by exactly one
	a_fetch_step: assert property (
		@(posedge __clk) disable iff (reset)
		fire && (cmd_op == pa_pkg::op_fetch) |=> ic == $past(ic) + 1'b1
	) else $error("pa_addr: ic did not step by one after fetch");

endmodule

/* design/pa_alu.sv */
// P-A arithmetic unit built from four slices joined by a carry lookahead

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_alu (
	input  logic [0:`PA_WORD_WIDTH-1] ac,
	input  logic [0:`PA_WORD_WIDTH-1] cmd_data,
	input  pa_pkg::pa_op              cmd_op,
	output logic [0:`PA_WORD_WIDTH-1] f,
	output logic                      carry,
	output logic                      zero,
	output logic                      sign
);

	localparam int SLICES = `PA_WORD_WIDTH / `PA_SLICE_WIDTH;
	localparam int PAIRS = `PA_WORD_WIDTH / 2;

	logic [0:SLICES-1] g;
	logic [0:SLICES-1] p;
	logic [0:SLICES-1] c_in;
	logic              c0;
	logic              cout;
	logic              arith;
	logic [0:PAIRS-1]  z_pair;

	// carry into the least significant slice
	assign c0 = (cmd_op == pa_pkg::op_sub);

	// slice 0 holds bits 0..3, the most significant nibble
	for (genvar i = 0; i < SLICES; i++) begin : g_slice
		pa_slice slice_i (
			.a   (ac[i*`PA_SLICE_WIDTH +: `PA_SLICE_WIDTH]),
			.b   (cmd_data[i*`PA_SLICE_WIDTH +: `PA_SLICE_WIDTH]),
			.op  (cmd_op),
			.cin (c_in[i]),
			.f   (f[i*`PA_SLICE_WIDTH +: `PA_SLICE_WIDTH]),
			.g   (g[i]),
			.p   (p[i])
		);
	end

	// lookahead across four slices, one level deep
	assign c_in[3] = c0;
	assign c_in[2] = g[3] | (p[3] & c0);
	assign c_in[1] = g[2] | (p[2] & g[3]) | (p[2] & p[3] & c0);
	assign c_in[0] = g[1] | (p[1] & g[2]) | (p[1] & p[2] & g[3])
		| (p[1] & p[2] & p[3] & c0);
	assign cout = g[0] | (p[0] & g[1]) | (p[0] & p[1] & g[2])
		| (p[0] & p[1] & p[2] & g[3]) | (p[0] & p[1] & p[2] & p[3] & c0);

	// carry only means something for add and subtract
	assign arith = (cmd_op == pa_pkg::op_add) || (cmd_op == pa_pkg::op_sub);
	assign carry = arith ? cout : 1'b0;

	// zero detect from NOR of bit pairs
	for (genvar k = 0; k < PAIRS; k++) begin : g_zero
		assign z_pair[k] = ~(f[2*k] | f[2*k+1]);
	end
	assign zero = &z_pair;

	assign sign = f[0];

	always_comb begin
		assert (cmd_op inside {pa_pkg::op_load, pa_pkg::op_add, pa_pkg::op_sub,
			pa_pkg::op_and, pa_pkg::op_or, pa_pkg::op_xor, pa_pkg::op_load_ar,
			pa_pkg::op_load_ic, pa_pkg::op_fetch})
		else $error("pa_alu: opcode %0d is not a defined command", cmd_op);
	end

endmodule

/* design/pa_control.sv */
// P-A control with command handshake, accumulator and merged response register

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_control (
	input  logic                      __clk,
	input  logic                      reset,
	// command channel
	input  logic                      cmd_valid,
	input  pa_pkg::pa_op              cmd_op,
	input  logic [0:`PA_WORD_WIDTH-1] cmd_data,
	output logic                      cmd_ready,
	// ALU results
	input  logic [0:`PA_WORD_WIDTH-1] f,
	input  logic                      carry,
	input  logic                      zero,
	input  logic                      sign,
	// address block results
	input  logic [0:`PA_WORD_WIDTH-1] addr,
	input  logic                      match,
	output logic                      fire,
	output logic [0:`PA_WORD_WIDTH-1] ac,
	// response channel
	input  logic                      rsp_ready,
	output logic                      rsp_valid,
	output logic [0:`PA_WORD_WIDTH-1] rsp_data,
	output logic                      rsp_zero,
	output logic                      rsp_carry,
	output logic                      rsp_sign,
	output logic [0:`PA_WORD_WIDTH-1] rsp_addr,
	output logic                      rsp_match
);

	logic                      arith_op;
	logic                      addr_load;
	logic [0:`PA_WORD_WIDTH-1] word;
	logic                      word_zero;
	logic                      word_carry;
	logic                      word_sign;

	// slot frees up when the held response is taken
	assign cmd_ready = ~rsp_valid | rsp_ready;
	assign fire = cmd_valid & cmd_ready;

	assign arith_op = cmd_op inside {pa_pkg::op_load, pa_pkg::op_add, pa_pkg::op_sub,
		pa_pkg::op_and, pa_pkg::op_or, pa_pkg::op_xor};
	assign addr_load = (cmd_op == pa_pkg::op_load_ar) || (cmd_op == pa_pkg::op_load_ic);

	// merge by op class
	always_comb begin
		if (arith_op) begin
			word = f;
			word_zero = zero;
			word_carry = carry;
			word_sign = sign;
		end else begin
			// address ops report the bus address, loads the new value
			word = addr_load ? cmd_data : addr;
			word_zero = (word == '0);
			word_carry = 1'b0;
			word_sign = word[0];
		end
	end

	always_ff @(posedge __clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			ac <= '0;
		end else begin
			if (fire) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
			if (fire && arith_op) begin
				ac <= f;
			end
		end
	end

	// response payload is only written on a transfer
	always_ff @(posedge __clk) begin
		if (fire) begin
			rsp_data <= word;
			rsp_zero <= word_zero;
			rsp_carry <= word_carry;
			rsp_sign <= word_sign;
			rsp_addr <= addr;
			rsp_match <= match;
		end
	end

	// stalled response must not move
	a_rsp_hold: assert property (
		@(posedge __clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_addr)
			&& $stable({rsp_zero, rsp_carry, rsp_sign, rsp_match})
	) else $error("pa_control: response changed while stalled");

	// a waiting command must hold still
	a_cmd_hold: assert property (
		@(posedge __clk) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_data)
	) else $error("pa_control: command changed while waiting for ready");

endmodule

/* design/pa_macros.svh */
// Word and slice widths shared by the P-A arithmetic and address unit

`ifndef PA_MACROS_SVH
`define PA_MACROS_SVH

// data and address word, bit 0 is the most significant
`define PA_WORD_WIDTH 16

// one ALU slice, four of them make a word
`define PA_SLICE_WIDTH 4

`endif

/* design/pa_pkg.sv */
// Shared types of the P-A unit with the command opcode set

package pa_pkg;

	// command opcodes
	// arithmetic group works on ac, address group on ar and ic
	typedef enum logic [3:0] {
		// arithmetic
		op_load    = 4'd0,
		op_add     = 4'd1,
		op_sub     = 4'd2,
		op_and     = 4'd3,
		op_or      = 4'd4,
		op_xor     = 4'd5,
		// address
		op_load_ar = 4'd6,
		op_load_ic = 4'd7,
		op_fetch   = 4'd8
	} pa_op;

endpackage

/* design/pa_slice.sv */
// Four bit ALU slice producing one nibble plus group generate and propagate

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_slice (
	input  logic [0:`PA_SLICE_WIDTH-1] a,
	input  logic [0:`PA_SLICE_WIDTH-1] b,
	input  pa_pkg::pa_op               op,
	input  logic                       cin,
	output logic [0:`PA_SLICE_WIDTH-1] f,
	output logic                       g,
	output logic                       p
);

	// b is the operand nibble, a the accumulator nibble
	logic [0:`PA_SLICE_WIDTH-1] b_eff;
	logic [0:`PA_SLICE_WIDTH]   sum_raw;
	logic [0:`PA_SLICE_WIDTH-1] sum;

	// subtract adds the inverted operand, the +1 comes in as carry
	assign b_eff = (op == pa_pkg::op_sub) ? ~b : b;

	// sum without carry in, top bit is the nibble's own carry out
	assign sum_raw = {1'b0, a} + {1'b0, b_eff};

	assign sum = a + b_eff + {{(`PA_SLICE_WIDTH-1){1'b0}}, cin};

	// group generate and propagate for the lookahead
	assign g = sum_raw[0];
	assign p = &(a ^ b_eff);

	always_comb begin
		case (op)
			pa_pkg::op_add,
			pa_pkg::op_sub: f = sum;
			pa_pkg::op_and: f = a & b;
			pa_pkg::op_or:  f = a | b;
			pa_pkg::op_xor: f = a ^ b;
			// load and address ops pass the operand
			default:        f = b;
		endcase
	end

endmodule

/* design/pa_top.sv */
// P-A unit top level joining the ALU, the address block and the control

`timescale 1ns/1ns

`include "pa_macros.svh"

module pa_top (
	input  logic                      __clk,
	input  logic                      reset,
	// command channel
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	input  pa_pkg::pa_op              cmd_op,
	input  logic [0:`PA_WORD_WIDTH-1] cmd_data,
	// response channel
	output logic                      rsp_valid,
	input  logic                      rsp_ready,
	output logic [0:`PA_WORD_WIDTH-1] rsp_data,
	output logic                      rsp_zero,
	output logic                      rsp_carry,
	output logic                      rsp_sign,
	output logic [0:`PA_WORD_WIDTH-1] rsp_addr,
	output logic                      rsp_match,
	// static key word
	input  logic [0:`PA_WORD_WIDTH-1] key
);

	logic [0:`PA_WORD_WIDTH-1] ac;
	logic [0:`PA_WORD_WIDTH-1] f;
	logic                      carry;
	logic                      zero;
	logic                      sign;
	logic [0:`PA_WORD_WIDTH-1] addr;
	logic                      match;
	logic                      fire;

	pa_alu alu_i (
		.ac       (ac),
		.cmd_data (cmd_data),
		.cmd_op   (cmd_op),
		.f        (f),
		.carry    (carry),
		.zero     (zero),
		.sign     (sign)
	);

	pa_addr addr_i (
		.__clk    (__clk),
		.reset    (reset),
		.fire     (fire),
		.cmd_op   (cmd_op),
		.cmd_data (cmd_data),
		.key      (key),
		.addr     (addr),
		.match    (match)
	);

	pa_control control_i (
		.__clk     (__clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.f         (f),
		.carry     (carry),
		.zero      (zero),
		.sign      (sign),
		.addr      (addr),
		.match     (match),
		.fire      (fire),
		.ac        (ac),
		.rsp_ready (rsp_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_zero  (rsp_zero),
		.rsp_carry (rsp_carry),
		.rsp_sign  (rsp_sign),
		.rsp_addr  (rsp_addr),
		.rsp_match (rsp_match)
	);

endmodule

/* files.f */
+incdir+design
design/pa_pkg.sv
design/pa_slice.sv
design/pa_alu.sv
design/pa_addr.sv
design/pa_control.sv
design/pa_top.sv
bench/pa_tb.sv
